//--- verilog.f
+incdir+logic
logic/audio_pkg.sv
logic/audio_clock_gen.sv
logic/audio_frame_fsm.sv
logic/audio_dac_serializer.sv
logic/audio_adc_deserializer.sv
logic/audio_codec_if.sv
test/audio_codec_checker.sv
test/tb_audio_codec_if.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_audio_codec_if \
	-f verilog.f -Mdir obj_dir -o sim_tb \
	> build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qx "ALL TESTS PASSED" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }

//--- test/tb_audio_codec_if.sv
// testbench with clock, reset, codec model, reference split, checks and watchdog
`default_nettype none

`include "audio_defines.svh"

module tb_audio_codec_if;

	import audio_pkg::*;

	localparam int HALF_CYCLES  = `AUD_BCK_HALF;
	localparam int FRAME_CYCLES = 2 * `AUD_BCK_HALF * `AUD_FRAME_BITS;
	localparam int N_FRAMES     = 10;
	localparam int N_AFTER      = 3;
	localparam int TIMEOUT      = (N_FRAMES + N_AFTER + 4) * FRAME_CYCLES;
	localparam int DRIVE_DELAY  = 1;
	localparam logic [31:0] SEED = 32'ha419_bc4b;

	logic        iCLK_18_4 = 1'b0;
	logic        iRST_N    = 1'b0;
	codec_pins_t pins;
	logic        adcdat   = 1'b0;
	stereo_t     dac_pair = '0;
	logic        sample_req;
	stereo_t     adc_pair;
	logic        adc_valid;

	// expected words with the oldest first
	logic [31:0] dac_expect[$];
	logic [31:0] adc_expect[$];
	logic [31:0] lfsr      = SEED;
	logic [31:0] dac_next  = '0;
	logic [31:0] adc_next  = '0;
	logic [31:0] adc_shift = '0;
	logic [31:0] dac_word  = '0;
	logic [31:0] popped    = '0;
	int          adc_bits  = 0;
	int          dac_bits  = -1;
	int          cycle     = -1;
	int          req_cycle = -1;
	int          toggle_cycle = 0;
	int          dac_done  = 0;
	int          adc_done  = 0;
	int          checks    = 0;
	int          errors    = 0;
	logic        prev_bck  = 1'b0;
	logic        drv_bck   = 1'b0;
	logic        req_seen  = 1'b0;

	audio_codec_if i_audio_codec_if (
		.iCLK_18_4  (iCLK_18_4),
		.iRST_N     (iRST_N),
		.pins       (pins),
		.adcdat     (adcdat),
		.dac_pair   (dac_pair),
		.sample_req (sample_req),
		.adc_pair   (adc_pair),
		.adc_valid  (adc_valid)
	);

	bind audio_codec_if audio_codec_checker i_codec_checker (
		.iCLK_18_4  (iCLK_18_4),
		.iRST_N     (iRST_N),
		.pins       (pins),
		.sample_req (sample_req),
		.adc_valid  (adc_valid)
	);

	initial
	begin
		forever #10 iCLK_18_4 = ~iCLK_18_4;
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		lfsr_next = state >> 1;
		if (state[0])
			lfsr_next = lfsr_next ^ 32'h8020_0003;
	endfunction

	// one lfsr step per bit taken
	task automatic draw_word(output logic [31:0] word);
		int i;
		word = '0;
		for (i = 0; i < 32; i++)
		begin
			word = {word[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// serial word to pair where the first 16 bits are left and each half is MSB first
	function automatic stereo_t serial_to_pair(input logic [31:0] word);
		stereo_t     pair;
		logic [31:0] bits;
		int          i;
		pair = '0;
		bits = word;
		for (i = 0; i < 32; i++)
		begin
			if (i < 16)
				pair.left = {pair.left[14:0], bits[31]};
			else
				pair.right = {pair.right[14:0], bits[31]};
			bits = bits << 1;
		end
		return pair;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("ERROR %s", what);
	endtask

	// three cycles low and released just after a rising edge
	task automatic hold_reset();
		repeat (3) @(posedge iCLK_18_4);
		#DRIVE_DELAY;
		iRST_N = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// compare process sampling mid cycle
	////////////////////////////////////////////////////////////

	always @(negedge iCLK_18_4)
	begin
		if (!iRST_N)
		begin
			check_value("outputs in reset", 32'b0, {27'b0, pins, sample_req, adc_valid});
			cycle        = -1;
			toggle_cycle = 0;
			req_cycle    = -1;
			dac_bits     = -1;
			prev_bck     = 1'b0;
			req_seen     = 1'b0;
			dac_expect.delete();
			adc_expect.delete();
			draw_word(dac_next);
		end
		else
		begin
			// cycle counts rising edges since release
			cycle++;
			if (req_seen)
				check_value("bck falls after sample_req", 32'b0, 32'(pins.bck));
			// serializer holds zeros until the first load
			if (req_cycle < 0)
				check_value("dacdat before first frame", 32'b0, 32'(pins.dacdat));
			if (pins.bck != prev_bck)
			begin
				// first rise 36 cycles after release and then every 36
				check_value("bck toggle", 32'(toggle_cycle + HALF_CYCLES), 32'(cycle));
				toggle_cycle = cycle;
				// codec side dac capture on the rise
				if (pins.bck && dac_bits >= 0)
				begin
					dac_word = {dac_word[30:0], pins.dacdat};
					dac_bits++;
					if (dac_bits == 32)
					begin
						dac_bits = -1;
						if (dac_expect.size() == 0)
							report_problem("dac frame ended with no pair latched");
						else
						begin
							popped = dac_expect.pop_front();
							check_value("dac pair", popped, serial_to_pair(dac_word));
							dac_done++;
						end
					end
				end
			end
			if (sample_req)
			begin
				// strobe sits on the last cycle of bck high
				check_value("sample_req on bck high", 32'b1, 32'(pins.bck));
				check_value("sample_req spacing",
					32'(req_cycle < 0 ? 2 * HALF_CYCLES - 1 : req_cycle + FRAME_CYCLES),
					32'(cycle));
				req_cycle = cycle;
				dac_bits  = 0;
				// pair latched on this edge plus the next pair and adc frame
				dac_expect.push_back(dac_pair);
				draw_word(dac_next);
				draw_word(adc_next);
				adc_expect.push_back(adc_next);
			end
			// left half of the frame is lrck high
			check_value("lrck", 32'((req_cycle >= 0) && (cycle > req_cycle)
				&& (cycle <= req_cycle + FRAME_CYCLES / 2)), 32'(pins.lrck));
			if (adc_valid)
			begin
				if (adc_expect.size() == 0)
					report_problem("adc_valid with no frame driven");
				else
				begin
					popped = adc_expect.pop_front();
					check_value("adc pair", serial_to_pair(popped), adc_pair);
					adc_done++;
				end
			end
			req_seen = sample_req;
			prev_bck = pins.bck;
		end
	end

	////////////////////////////////////////////////////////////
	// codec model and host driver
	////////////////////////////////////////////////////////////

	always @(posedge iCLK_18_4)
	begin
		#DRIVE_DELAY;
		if (!iRST_N)
		begin
			dac_pair = dac_next;
			adc_bits = 0;
			drv_bck  = 1'b0;
		end
		else
		begin
			// request just ended so this edge latched dac_pair
			if (req_seen)
			begin
				dac_pair  = dac_next;
				adc_shift = adc_next;
				adc_bits  = 32;
			end
			// next adc bit on each falling bck with MSB first
			if (drv_bck && !pins.bck && adc_bits > 0)
			begin
				adcdat    = adc_shift[31];
				adc_shift = adc_shift << 1;
				adc_bits--;
			end
			drv_bck = pins.bck;
		end
	end

	////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		hold_reset();
		wait (dac_done >= N_FRAMES && adc_done >= N_FRAMES);
		// reset deep inside the left channel
		wait (sample_req);
		repeat (1000) @(posedge iCLK_18_4);
		#DRIVE_DELAY;
		iRST_N = 1'b0;
		#DRIVE_DELAY;
		check_value("outputs at async reset", 32'b0, {27'b0, pins, sample_req, adc_valid});
		hold_reset();
		wait (dac_done >= N_FRAMES + N_AFTER && adc_done >= N_FRAMES + N_AFTER);
		repeat (4) @(posedge iCLK_18_4);
		$display("dac frames %0d, adc frames %0d, checks %0d, errors %0d",
			dac_done, adc_done, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// bound by the frame count
	initial
	begin
		repeat (TIMEOUT) @(posedge iCLK_18_4);
		$display("timeout, frames stopped completing after %0d cycles", TIMEOUT);
		$display("dac frames %0d, adc frames %0d, checks %0d, errors %0d",
			dac_done, adc_done, checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/audio_codec_checker.sv
// concurrent assertions on codec pin timing and host strobe width
`default_nettype none

module audio_codec_checker (
	input logic                   iCLK_18_4,
	input logic                   iRST_N,
	input audio_pkg::codec_pins_t pins,
	input logic                   sample_req,
	input logic                   adc_valid
);

	////////////////////////////////////////////////////////////
	// host strobes
	////////////////////////////////////////////////////////////

	// one cycle per frame, never stretched
	req_one_cycle: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		sample_req |=> !sample_req
	) else $error("sample_req high for more than one cycle");

	valid_one_cycle: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		adc_valid |=> !adc_valid
	) else $error("adc_valid high for more than one cycle");

	////////////////////////////////////////////////////////////
	// codec pins
	////////////////////////////////////////////////////////////

	// lrck and bck both move on the falling bck edge
	lrck_on_fall: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		$changed(pins.lrck) |-> $fell(pins.bck)
	) else $error("lrck changed away from a falling bck edge");

	// codec samples on the rise, so no change while bck is high
	dacdat_stable: assert property (
		@(posedge iCLK_18_4) disable iff (!iRST_N)
		pins.bck |-> $stable(pins.dacdat)
	) else $error("dacdat changed while bck was high");

endmodule

`default_nettype wire

//--- logic/audio_codec_if.sv
// codec interface top level joining divider, frame FSM and data paths
`default_nettype none

module audio_codec_if (
	input  logic                   iCLK_18_4,
	input  logic                   iRST_N,
	output audio_pkg::codec_pins_t pins,
	input  logic                   adcdat,
	input  audio_pkg::stereo_t     dac_pair,
	output logic                   sample_req,
	output audio_pkg::stereo_t     adc_pair,
	output logic                   adc_valid
);

	import audio_pkg::*;

	logic       bck;
	logic       lrck;
	logic       dacdat;
	logic       frame_start;
	logic       capture;
	bck_edges_t edges;

	////////////////////////////////////////////////////////////
	// timing
	////////////////////////////////////////////////////////////

	// paces everything below
	audio_clock_gen i_clock_gen (
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.bck       (bck),
		.edges     (edges)
	);

	audio_frame_fsm i_frame_fsm (
		.iCLK_18_4   (iCLK_18_4),
		.iRST_N      (iRST_N),
		.edges       (edges),
		.lrck        (lrck),
		.frame_start (frame_start),
		.capture     (capture)
	);

	////////////////////////////////////////////////////////////
	// data paths
	////////////////////////////////////////////////////////////

	audio_dac_serializer i_dac_serializer (
		.iCLK_18_4   (iCLK_18_4),
		.iRST_N      (iRST_N),
		.edges       (edges),
		.frame_start (frame_start),
		.dac_pair    (dac_pair),
		.dacdat      (dacdat)
	);

	audio_adc_deserializer i_adc_deserializer (
		.iCLK_18_4 (iCLK_18_4),
		.iRST_N    (iRST_N),
		.edges     (edges),
		.capture   (capture),
		.adcdat    (adcdat),
		.adc_pair  (adc_pair),
		.adc_valid (adc_valid)
	);

	// codec pins
	assign pins = '{bck: bck, lrck: lrck, dacdat: dacdat};

	// host sees the load strobe directly
	assign sample_req = frame_start;

endmodule

`default_nettype wire

//--- logic/audio_adc_deserializer.sv
// ADC shift register with holding register and valid strobe
`default_nettype none

`include "audio_defines.svh"

module audio_adc_deserializer (
	input  logic                  iCLK_18_4,
	input  logic                  iRST_N,
	input  audio_pkg::bck_edges_t edges,
	input  logic                  capture,
	input  logic                  adcdat,
	output audio_pkg::stereo_t    adc_pair,
	output logic                  adc_valid
);

	import audio_pkg::*;

	audio_frame_u                shift_q;
	audio_frame_u                hold_q;
	logic [`AUD_FRAME_BITS-1:0]  shift_in;

	// word including the bit arriving this cycle
	assign shift_in = {shift_q.raw[`AUD_FRAME_BITS-2:0], adcdat};

	////////////////////////////////////////////////////////////
	// serial in
	////////////////////////////////////////////////////////////

	// adcdat is settled since the last falling bck
	always_ff @(posedge iCLK_18_4)
	begin
		if (edges.bck_rise)
			shift_q.raw <= shift_in;
	end

	////////////////////////////////////////////////////////////
	// hand off
	////////////////////////////////////////////////////////////

	// capture sits on the rise of position 31
	// so the copy holds a whole frame, first bit at the top
	always_ff @(posedge iCLK_18_4)
	begin
		if (capture)
			hold_q.raw <= shift_in;
	end

	// left is the upper half
	assign adc_pair = hold_q.stereo;

	// one cycle behind capture, lines up with the new hold value
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
			adc_valid <= 1'b0;
		else
			adc_valid <= capture;
	end

endmodule

`default_nettype wire

//--- logic/audio_dac_serializer.sv
// DAC shift register, loads a stereo pair and shifts it out MSB first
`default_nettype none

`include "audio_defines.svh"

module audio_dac_serializer (
	input  logic                  iCLK_18_4,
	input  logic                  iRST_N,
	input  audio_pkg::bck_edges_t edges,
	input  logic                  frame_start,
	input  audio_pkg::stereo_t    dac_pair,
	output logic                  dacdat
);

	import audio_pkg::*;

	audio_frame_u shift_q;

	////////////////////////////////////////////////////////////
	// load and shift
	////////////////////////////////////////////////////////////

	// frame_start always lands on a bck_fall, load wins
	// dacdat moves only with falling bck, codec samples on the rise
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			// keeps dacdat low out of reset
			shift_q.raw <= '0;
		end
		else if (frame_start)
		begin
			shift_q.stereo <= dac_pair;
		end
		else if (edges.bck_fall)
		begin
			shift_q.raw <= {shift_q.raw[`AUD_FRAME_BITS-2:0], 1'b0};
		end
	end

	// left MSB first, right LSB last
	assign dacdat = shift_q.raw[`AUD_FRAME_BITS-1];

endmodule

`default_nettype wire

//--- logic/audio_frame_fsm.sv
// channel and bit position FSM issuing lrck, frame start and capture
`default_nettype none

`include "audio_defines.svh"

module audio_frame_fsm (
	input  logic                  iCLK_18_4,
	input  logic                  iRST_N,
	input  audio_pkg::bck_edges_t edges,
	output logic                  lrck,
	output logic                  frame_start,
	output logic                  capture
);

	localparam int unsigned POS_W = `AUD_POS_W;
	// last left bit and last bit of the frame
	localparam logic [POS_W-1:0] LEFT_LAST = POS_W'(`AUD_DATA_WIDTH - 1);
	localparam logic [POS_W-1:0] POS_LAST  = POS_W'(`AUD_FRAME_BITS - 1);

	typedef enum logic [1:0] {
		IDLE,
		LEFT,
		RIGHT
	} state_t;

	state_t           state;
	state_t           state_nxt;
	logic [POS_W-1:0] pos;
	logic [POS_W-1:0] pos_nxt;

	////////////////////////////////////////////////////////////
	// next position, taken only on bck_fall
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		pos_nxt   = pos;
		case (state)
			IDLE:
			begin
				// first fall after reset opens the frame
				state_nxt = LEFT;
				pos_nxt   = '0;
			end
			LEFT:
			begin
				pos_nxt = pos + 1'b1;
				if (pos == LEFT_LAST)
					state_nxt = RIGHT;
			end
			RIGHT:
			begin
				// 31 wraps to 0 in five bits
				pos_nxt = pos + 1'b1;
				if (pos == POS_LAST)
					state_nxt = LEFT;
			end
			default:
			begin
				state_nxt = IDLE;
				pos_nxt   = '0;
			end
		endcase
	end

	// lrck follows the state, high for left
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			state <= IDLE;
			pos   <= '0;
			lrck  <= 1'b0;
		end
		else if (edges.bck_fall)
		begin
			state <= state_nxt;
			pos   <= pos_nxt;
			lrck  <= (state_nxt == LEFT);
		end
	end

	////////////////////////////////////////////////////////////
	// frame controls
	////////////////////////////////////////////////////////////

	// the fall that enters position 0 of a left channel
	assign frame_start = edges.bck_fall && (state_nxt == LEFT) && (pos_nxt == '0);

	// last adc bit arrives on this rise
	assign capture = edges.bck_rise && (state == RIGHT) && (pos == POS_LAST);

endmodule

`default_nettype wire

//--- logic/audio_clock_gen.sv
// bit clock divider with rise and fall strobe decode
`default_nettype none

`include "audio_defines.svh"

module audio_clock_gen (
	input  logic                   iCLK_18_4,
	input  logic                   iRST_N,
	output logic                   bck,
	output audio_pkg::bck_edges_t  edges
);

	////////////////////////////////////////////////////////////
	// half period counter
	////////////////////////////////////////////////////////////

	localparam int unsigned CNT_W = `AUD_BCK_CNT_W;
	// last count before bck toggles
	localparam logic [CNT_W-1:0] CNT_WRAP = CNT_W'(`AUD_BCK_HALF - 1);

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	// end of a half period
	assign wrap = (cnt == CNT_WRAP);

	// 0..35 then toggle, so bck period is 72 reference cycles
	always_ff @(posedge iCLK_18_4 or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			cnt <= '0;
			bck <= 1'b0;
		end
		else if (wrap)
		begin
			cnt <= '0;
			bck <= ~bck;
		end
		else
		begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// edge strobes
	////////////////////////////////////////////////////////////

	// wrap plus current level tells which way bck goes next
	// downstream registers update on the same edge as bck
	assign edges = '{
		bck_rise: wrap && !bck,
		bck_fall: wrap && bck
	};

endmodule

`default_nettype wire

//--- logic/audio_pkg.sv
// sample, stereo pair, frame union, codec pin and bck strobe types
`default_nettype none

`include "audio_defines.svh"

package audio_pkg;

	////////////////////////////////////////////////////////////
	// sample data
	////////////////////////////////////////////////////////////

	// one signed channel word
	typedef logic signed [`AUD_DATA_WIDTH-1:0] sample_t;

	// left sits in the upper half
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// same 32 bits seen as a shift word or as a pair
	// shifting goes through raw, hand off through stereo
	typedef union packed {
		logic [`AUD_FRAME_BITS-1:0] raw;
		stereo_t stereo;
	} audio_frame_u;

	////////////////////////////////////////////////////////////
	// codec side
	////////////////////////////////////////////////////////////

	// outputs toward the codec
	typedef struct packed {
		logic bck;
		logic lrck;
		logic dacdat;
	} codec_pins_t;

	// single cycle strobes, high in the cycle before bck changes
	typedef struct packed {
		logic bck_rise;
		logic bck_fall;
	} bck_edges_t;

endpackage

`default_nettype wire

//--- logic/audio_defines.svh
// reference clock, sample rate, word width and derived divider constants
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

////////////////////////////////////////////////////////////
// fixed codec configuration
////////////////////////////////////////////////////////////

// 18.432 MHz reference
`define AUD_REF_CLK      18432000
// 8 kHz stereo frames
`define AUD_SAMPLE_RATE  8000
// bits per channel
`define AUD_DATA_WIDTH   16
// left plus right
`define AUD_FRAME_BITS   (2 * `AUD_DATA_WIDTH)

// reference cycles per half bck period, 36 here
`define AUD_BCK_HALF     (`AUD_REF_CLK / (`AUD_SAMPLE_RATE * `AUD_FRAME_BITS * 2))
// divider and position counter widths
`define AUD_BCK_CNT_W    $clog2(`AUD_BCK_HALF)
`define AUD_POS_W        $clog2(`AUD_FRAME_BITS)

`endif
